// File: include/dup_config.svh
`ifndef DUP_CONFIG_SVH
`define DUP_CONFIG_SVH

// Device register word addresses
`define DUP_TXCSR_ADDR    3'd2
`define DUP_TXDBUF_ADDR   3'd3

// Clocks per serial bit with a minimum of 2
`define DUP_BIT_DIV       4

// TXCSR field positions
`define DUP_TXCSR_DLE     15
`define DUP_TXCSR_MDO     14
`define DUP_TXCSR_MCO     13
`define DUP_TXCSR_MSEL_HI 12
`define DUP_TXCSR_MSEL_LO 11
`define DUP_TXCSR_MDI     10
`define DUP_TXCSR_ACT     9
`define DUP_TXCSR_INIT    8
`define DUP_TXCSR_DONE    7
`define DUP_TXCSR_TXIE    6
`define DUP_TXCSR_SEND    4
`define DUP_TXCSR_HDX     3

// TXDBUF flag positions
`define DUP_TXDBUF_TSOM   8
`define DUP_TXDBUF_TEOM   9

`endif

// File: logic/dupPkg.sv
package dupPkg;

   // One device bus cycle from the adapter
   typedef struct packed {
      logic [2:0]  addr;
      logic        write;
      logic        read;
      logic        loByte;
      logic        hiByte;
      logic        devReset;
      logic [35:0] dataIn;
   } devBus_t;

   // Decoded register write strobes
   typedef struct packed {
      logic        csrWrite;
      logic        dbufWrite;
      logic        loByte;
      logic        hiByte;
      logic [15:0] data;
   } regStrobe_t;

   // Control fields taken from TXCSR
   typedef struct packed {
      logic init;
      logic send;
      logic hdx;
   } txCtrl_t;

   // Buffered byte and its flags
   typedef struct packed {
      logic [7:0] data;
      logic       tsom;
      logic       teom;
      logic       full;
   } txDbuf_t;

   // Shifter status with a single cycle take pulse
   typedef struct packed {
      logic dle;
      logic mdo;
      logic act;
      logic done;
      logic take;
   } txStatus_t;

endpackage

// File: logic/dupBusDecode.sv
`timescale 1ns/1ps

`include "dup_config.svh"

module dupBusDecode (
   input  logic                clk,
   input  logic                rst,
   input  dupPkg::devBus_t     bus,
   input  logic [15:0]         csrWord,
   input  logic [15:0]         dbufWord,
   output dupPkg::regStrobe_t  strobe,
   output logic [15:0]         regData
);

   logic csrSel;
   logic dbufSel;
   logic laneHit;

   ///////////////////////////////////////////////////////////////////////
   // Address match
   ///////////////////////////////////////////////////////////////////////

   assign csrSel  = (bus.addr == `DUP_TXCSR_ADDR);
   assign dbufSel = (bus.addr == `DUP_TXDBUF_ADDR);

   // At least one byte lane must be enabled for a write
   assign laneHit = bus.loByte | bus.hiByte;

   ///////////////////////////////////////////////////////////////////////
   // Write strobes
   ///////////////////////////////////////////////////////////////////////

   always_comb
   begin
      strobe.csrWrite  = bus.write & csrSel & laneHit;
      strobe.dbufWrite = bus.write & dbufSel & laneHit;
      strobe.loByte    = bus.loByte;
      strobe.hiByte    = bus.hiByte;
      // Only the low word of the bus data is used
      strobe.data      = bus.dataIn[15:0];
   end

   ///////////////////////////////////////////////////////////////////////
   // Read-back
   ///////////////////////////////////////////////////////////////////////

   // Holds the last word read until the next read strobe
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         regData <= '0;
      else if (bus.read)
      begin
         if (csrSel)
            regData <= csrWord;
         else if (dbufSel)
            regData <= dbufWord;
         else
            regData <= '0;
      end
   end

endmodule

// File: logic/dupTxCsr.sv
`timescale 1ns/1ps

`include "dup_config.svh"

module dupTxCsr (
   input  logic                clk,
   input  logic                rst,
   input  logic                devReset,
   input  dupPkg::regStrobe_t  strobe,
   input  dupPkg::txStatus_t   status,
   output dupPkg::txCtrl_t     ctrl,
   output logic [15:0]         csrWord,
   output logic                txIntr
);

   logic       init;
   logic       hiWrite;
   logic       loWrite;
   logic       mco;
   logic [1:0] msel;
   logic       mdi;
   logic       txie;
   logic       send;
   logic       hdx;

   assign hiWrite = strobe.csrWrite & strobe.hiByte;
   assign loWrite = strobe.csrWrite & strobe.loByte;

   // INIT from the device reset or a high byte write with bit 8 set
   assign init = devReset | (hiWrite & strobe.data[`DUP_TXCSR_INIT]);

   ///////////////////////////////////////////////////////////////////////
   // Writable fields
   ///////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         mco  <= 1'b0;
         msel <= 2'b00;
         mdi  <= 1'b0;
         txie <= 1'b0;
         send <= 1'b0;
         hdx  <= 1'b0;
      end
      else if (init)
      begin
         mco  <= 1'b0;
         msel <= 2'b00;
         mdi  <= 1'b0;
         txie <= 1'b0;
         send <= 1'b0;
         hdx  <= 1'b0;
      end
      else
      begin
         // Maintenance fields live in the high byte
         if (hiWrite)
         begin
            mco  <= strobe.data[`DUP_TXCSR_MCO];
            msel <= strobe.data[`DUP_TXCSR_MSEL_HI:`DUP_TXCSR_MSEL_LO];
            mdi  <= strobe.data[`DUP_TXCSR_MDI];
         end
         // Transmitter controls in the low byte
         if (loWrite)
         begin
            txie <= strobe.data[`DUP_TXCSR_TXIE];
            send <= strobe.data[`DUP_TXCSR_SEND];
            hdx  <= strobe.data[`DUP_TXCSR_HDX];
         end
      end
   end

   assign ctrl = '{init: init, send: send, hdx: hdx};

   // Status word with reserved bits reading zero
   always_comb
   begin
      csrWord                                            = '0;
      csrWord[`DUP_TXCSR_DLE]                            = status.dle;
      csrWord[`DUP_TXCSR_MDO]                            = status.mdo;
      csrWord[`DUP_TXCSR_MCO]                            = mco;
      csrWord[`DUP_TXCSR_MSEL_HI:`DUP_TXCSR_MSEL_LO]     = msel;
      csrWord[`DUP_TXCSR_MDI]                            = mdi;
      csrWord[`DUP_TXCSR_ACT]                            = status.act;
      csrWord[`DUP_TXCSR_INIT]                           = init;
      csrWord[`DUP_TXCSR_DONE]                           = status.done;
      csrWord[`DUP_TXCSR_TXIE]                           = txie;
      csrWord[`DUP_TXCSR_SEND]                           = send;
      csrWord[`DUP_TXCSR_HDX]                            = hdx;
   end

   // Interrupt request level
   assign txIntr = txie & status.done;

endmodule

// File: logic/dupTxDbuf.sv
`timescale 1ns/1ps

`include "dup_config.svh"

module dupTxDbuf (
   input  logic                clk,
   input  logic                rst,
   input  dupPkg::regStrobe_t  strobe,
   input  dupPkg::txCtrl_t     ctrl,
   input  dupPkg::txStatus_t   status,
   output dupPkg::txDbuf_t     dbuf,
   output logic [15:0]         dbufWord
);

   logic [7:0] data;
   logic       tsom;
   logic       teom;
   logic       full;

   ///////////////////////////////////////////////////////////////////////
   // Buffer register
   ///////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         data <= 8'h00;
         tsom <= 1'b0;
         teom <= 1'b0;
         full <= 1'b0;
      end
      else if (ctrl.init)
      begin
         data <= 8'h00;
         tsom <= 1'b0;
         teom <= 1'b0;
         full <= 1'b0;
      end
      else if (strobe.dbufWrite)
      begin
         // Low byte loads the character and high byte the framing flags
         if (strobe.loByte)
            data <= strobe.data[7:0];
         if (strobe.hiByte)
         begin
            tsom <= strobe.data[`DUP_TXDBUF_TSOM];
            teom <= strobe.data[`DUP_TXDBUF_TEOM];
         end
         // A write wins over a take in the same cycle
         full <= 1'b1;
      end
      else if (status.take)
         full <= 1'b0;
   end

   assign dbuf = '{data: data, tsom: tsom, teom: teom, full: full};

   always_comb
   begin
      dbufWord                   = '0;
      dbufWord[7:0]              = data;
      dbufWord[`DUP_TXDBUF_TSOM] = tsom;
      dbufWord[`DUP_TXDBUF_TEOM] = teom;
   end

endmodule

// File: logic/dupTxShifter.sv
`timescale 1ns/1ps

`include "dup_config.svh"

module dupTxShifter (
   input  logic               clk,
   input  logic               rst,
   input  dupPkg::txCtrl_t    ctrl,
   input  dupPkg::txDbuf_t    dbuf,
   output dupPkg::txStatus_t  status,
   output logic               txData,
   output logic               txBitClk
);

   localparam int bitDiv   = `DUP_BIT_DIV;
   localparam int divWidth = $clog2(bitDiv);
   localparam logic [divWidth-1:0] divLast = divWidth'(bitDiv - 1);
   localparam logic [divWidth-1:0] divMid  = divWidth'(bitDiv / 2 - 1);

   logic [divWidth-1:0] divCnt;
   logic [7:0]          shiftReg;
   logic [2:0]          bitCnt;
   logic                bitEdge;
   logic                lastBit;
   logic                endOfByte;
   logic                take;
   logic                underrun;
   logic                fullRise;
   logic                shifting;
   logic                lastTeom;
   logic                act;
   logic                dle;
   logic                done;
   logic                fullDly;

   ///////////////////////////////////////////////////////////////////////
   // Bit-rate divider
   ///////////////////////////////////////////////////////////////////////

   // Free running with one bit boundary every bitDiv clocks
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         divCnt <= '0;
      else if (bitEdge)
         divCnt <= '0;
      else
         divCnt <= divCnt + 1'b1;
   end

   assign bitEdge   = (divCnt == divLast);
   assign lastBit   = (bitCnt == 3'd7);
   assign endOfByte = bitEdge & shifting & lastBit;

   // Load the buffer when idle or after the eighth bit
   assign take = bitEdge & ctrl.send & dbuf.full & ~ctrl.init & (~shifting | lastBit);

   // Byte ended with nothing queued and the message still open
   assign underrun = endOfByte & ~take & ctrl.send & ~lastTeom;
   assign fullRise = dbuf.full & ~fullDly;

   ///////////////////////////////////////////////////////////////////////
   // Shift register
   ///////////////////////////////////////////////////////////////////////

   // Shifts right with ones behind so the line idles at mark
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         shiftReg <= 8'hFF;
         bitCnt   <= 3'd0;
         shifting <= 1'b0;
         lastTeom <= 1'b0;
      end
      else if (ctrl.init)
      begin
         shiftReg <= 8'hFF;
         bitCnt   <= 3'd0;
         shifting <= 1'b0;
         lastTeom <= 1'b0;
      end
      else if (take)
      begin
         shiftReg <= dbuf.data;
         bitCnt   <= 3'd0;
         shifting <= 1'b1;
         lastTeom <= dbuf.teom;
      end
      else if (bitEdge & shifting)
      begin
         shiftReg <= {1'b1, shiftReg[7:1]};
         bitCnt   <= bitCnt + 3'd1;
         if (lastBit)
            shifting <= 1'b0;
      end
   end

   ///////////////////////////////////////////////////////////////////////
   // Status flags and bit clock
   ///////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         act      <= 1'b0;
         dle      <= 1'b0;
         done     <= 1'b1;
         fullDly  <= 1'b0;
         txBitClk <= 1'b0;
      end
      else
      begin
         fullDly  <= dbuf.full;
         // Strobe in the middle of each data bit only
         txBitClk <= shifting & (divCnt == divMid) & ~ctrl.init;
         if (ctrl.init)
         begin
            act  <= 1'b0;
            dle  <= 1'b0;
            done <= 1'b1;
         end
         else
         begin
            // Half duplex turns the line around instead of flagging late data
            if (take)
               act <= 1'b1;
            else if (endOfByte & (lastTeom | ~ctrl.send | ctrl.hdx))
               act <= 1'b0;
            else if (~shifting & ~ctrl.send)
               act <= 1'b0;
            if (underrun & ~ctrl.hdx)
               dle <= 1'b1;
            // Buffer free again once taken
            if (take)
               done <= 1'b1;
            else if (fullRise)
               done <= 1'b0;
         end
      end
   end

   assign txData = shiftReg[0];

   assign status = '{dle: dle, mdo: txData, act: act, done: done, take: take};

endmodule

// File: logic/dupTx.sv
`timescale 1ns/1ps

module dupTx (
   input  logic             clk,
   input  logic             rst,
   input  dupPkg::devBus_t  bus,
   output logic [15:0]      regData,
   output logic             txData,
   output logic             txBitClk,
   output logic             txIntr
);

   dupPkg::regStrobe_t strobe;
   dupPkg::txCtrl_t    ctrl;
   dupPkg::txDbuf_t    dbuf;
   dupPkg::txStatus_t  status;
   logic [15:0]        csrWord;
   logic [15:0]        dbufWord;

   ///////////////////////////////////////////////////////////////////////
   // Bus side
   ///////////////////////////////////////////////////////////////////////

   dupBusDecode busDecode (
      .clk      (clk),
      .rst      (rst),
      .bus      (bus),
      .csrWord  (csrWord),
      .dbufWord (dbufWord),
      .strobe   (strobe),
      .regData  (regData)
   );

   // Control and status register
   dupTxCsr txCsr (
      .clk      (clk),
      .rst      (rst),
      .devReset (bus.devReset),
      .strobe   (strobe),
      .status   (status),
      .ctrl     (ctrl),
      .csrWord  (csrWord),
      .txIntr   (txIntr)
   );

   // Data buffer
   dupTxDbuf txDbuf (
      .clk      (clk),
      .rst      (rst),
      .strobe   (strobe),
      .ctrl     (ctrl),
      .status   (status),
      .dbuf     (dbuf),
      .dbufWord (dbufWord)
   );

   ///////////////////////////////////////////////////////////////////////
   // Line side
   ///////////////////////////////////////////////////////////////////////

   dupTxShifter txShifter (
      .clk      (clk),
      .rst      (rst),
      .ctrl     (ctrl),
      .dbuf     (dbuf),
      .status   (status),
      .txData   (txData),
      .txBitClk (txBitClk)
   );

endmodule

// File: tests/dupTxTb.sv
`timescale 1ns/1ps

`include "dup_config.svh"

module dupTxTb;

   localparam int clkPeriod = 100;
   localparam int pollLimit = 200;
   localparam int byteLimit = `DUP_BIT_DIV * 8 * 3;

   logic              clk = 1'b0;
   logic              rst;
   dupPkg::devBus_t   bus;
   logic [15:0]       regData;
   logic              txData;
   logic              txBitClk;
   logic              txIntr;

   // Serial capture state
   logic [7:0]        rxBytes[$];
   logic [7:0]        rxShift = 8'h00;
   int                rxCount = 0;

   int                testErrors = 0;
   int                testsPassed = 0;
   int                testsFailed = 0;
   int                limitNs = 0;
   logic [8*24-1:0]   testName;
   logic              inTest = 1'b0;

   dupTx UUT (
      .clk      (clk),
      .rst      (rst),
      .bus      (bus),
      .regData  (regData),
      .txData   (txData),
      .txBitClk (txBitClk),
      .txIntr   (txIntr)
   );

   always #(clkPeriod / 2) clk = ~clk;

   // Bits arrive LSB first with one per bit strobe
   always @(negedge clk)
   begin
      if (!rst && txBitClk)
      begin
         rxShift = {txData, rxShift[7:1]};
         rxCount = rxCount + 1;
         if (rxCount == 8)
         begin
            rxBytes.push_back(rxShift);
            rxCount = 0;
         end
      end
   end

   ///////////////////////////////////////////////////////////////////////
   // Compare tasks
   ///////////////////////////////////////////////////////////////////////

   task automatic compareWord(input logic [15:0] got, input logic [15:0] exp);
      if (got !== exp)
      begin
         $display("** Error at %0t: register read %h, expected %h", $time, got, exp);
         testErrors++;
      end
   endtask

   task automatic compareByte(input logic [7:0] got, input logic [7:0] exp);
      if (got !== exp)
      begin
         $display("** Error at %0t: serial byte %h, expected %h", $time, got, exp);
         testErrors++;
      end
   endtask

   task automatic compareBit(input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("** Error at %0t: txIntr is %b, expected %b", $time, got, exp);
         testErrors++;
      end
   endtask

   ///////////////////////////////////////////////////////////////////////
   // Bus cycles
   ///////////////////////////////////////////////////////////////////////

   task automatic busWrite(input logic [2:0] addr, input logic [1:0] lanes,
                           input logic [15:0] data);
      @(posedge clk);
      bus.addr   <= addr;
      bus.loByte <= lanes[0];
      bus.hiByte <= lanes[1];
      bus.dataIn <= {20'h00000, data};
      bus.write  <= 1'b1;
      @(posedge clk);
      bus.write  <= 1'b0;
      bus.loByte <= 1'b0;
      bus.hiByte <= 1'b0;
   endtask

   // Word is valid the cycle after the read strobe
   task automatic busRead(input logic [2:0] addr, output logic [15:0] word);
      @(posedge clk);
      bus.addr <= addr;
      bus.read <= 1'b1;
      @(posedge clk);
      bus.read <= 1'b0;
      @(negedge clk);
      word = regData;
   endtask

   task automatic pulseDevReset;
      @(posedge clk);
      bus.devReset <= 1'b1;
      @(posedge clk);
      bus.devReset <= 1'b0;
   endtask

   task automatic pollReg(input logic [2:0] addr, input logic [15:0] mask,
                          input logic [15:0] value);
      int          tries;
      logic [15:0] word;
      tries = 0;
      busRead(addr, word);
      while ((word & mask) != value && tries < pollLimit)
      begin
         busRead(addr, word);
         tries++;
      end
      if ((word & mask) != value)
      begin
         $display("Gave up waiting for register %0d to reach %h under mask %h",
                  addr, value, mask);
         testErrors++;
      end
   endtask

   task automatic expectByte(input logic [7:0] exp);
      int waited;
      waited = 0;
      while (rxBytes.size() == 0 && waited < byteLimit)
      begin
         @(posedge clk);
         waited++;
      end
      if (rxBytes.size() == 0)
      begin
         $display("No serial byte arrived while waiting for %h", exp);
         testErrors++;
      end
      else
         compareByte(rxBytes.pop_front(), exp);
   endtask

   task automatic idleGap;
      repeat ($urandom_range(4, 1)) @(posedge clk);
   endtask

   task automatic closeTest;
      // Every serial bit of a test must belong to an expected byte
      if (rxBytes.size() != 0 || rxCount != 0)
      begin
         $display("Serial line carried %0d unexpected bytes and %0d stray bits",
                  rxBytes.size(), rxCount);
         testErrors++;
         rxBytes.delete();
         rxCount = 0;
      end
      if (inTest)
      begin
         if (testErrors == 0)
         begin
            $display("Test %0s passed", testName);
            testsPassed++;
         end
         else
         begin
            $display("Test %0s failed with %0d errors", testName, testErrors);
            testsFailed++;
         end
      end
      else if (testErrors != 0)
         testsFailed++;
      testErrors = 0;
   endtask

   ///////////////////////////////////////////////////////////////////////
   // Pattern interpreter
   ///////////////////////////////////////////////////////////////////////

   task automatic runPatterns(input int fd);
      int               code;
      byte              cmd;
      logic [8*128-1:0] skip;
      logic [2:0]       addr;
      logic [1:0]       lanes;
      logic [15:0]      data;
      logic [15:0]      mask;
      logic [15:0]      word;
      code = $fscanf(fd, " %c", cmd);
      while (code == 1)
      begin
         case (cmd)
            "#": code = $fgets(skip, fd);
            "T":
            begin
               closeTest();
               code   = $fscanf(fd, "%s", testName);
               inTest = 1'b1;
            end
            "W":
            begin
               code = $fscanf(fd, "%h %h %h", addr, lanes, data);
               busWrite(addr, lanes, data);
            end
            "R":
            begin
               code = $fscanf(fd, "%h %h", addr, data);
               busRead(addr, word);
               compareWord(word, data);
            end
            "P":
            begin
               code = $fscanf(fd, "%h %h %h", addr, mask, data);
               pollReg(addr, mask, data);
            end
            "X":
            begin
               code = $fscanf(fd, "%h", data);
               expectByte(data[7:0]);
            end
            "I":
            begin
               code = $fscanf(fd, "%h", data);
               @(negedge clk);
               compareBit(txIntr, data[0]);
            end
            "D": pulseDevReset();
            default:
            begin
               $display("Unknown pattern command %c", cmd);
               testErrors++;
            end
         endcase
         // Random idle time between bus commands
         if (cmd != "#")
            idleGap();
         code = $fscanf(fd, " %c", cmd);
      end
      closeTest();
   endtask

   initial
   begin
      int               fd;
      int               lineCount;
      logic [8*128-1:0] skip;
      rst <= 1'b1;
      bus <= '0;
      void'($urandom(13201));
      lineCount = 0;
      fd = $fopen("tests/dupTx_patterns.txt", "r");
      if (fd == 0)
      begin
         $display("Could not open the pattern file tests/dupTx_patterns.txt");
         testsFailed++;
      end
      else
      begin
         // First pass only sizes the watchdog
         while ($fgets(skip, fd) != 0)
         begin
            lineCount++;
         end
         $fclose(fd);
         limitNs = lineCount * (`DUP_BIT_DIV * 10 + 20) * clkPeriod;
         repeat (10) @(posedge clk);
         rst <= 1'b0;
         fd = $fopen("tests/dupTx_patterns.txt", "r");
         runPatterns(fd);
         $fclose(fd);
      end
      $display("Tests passed: %0d, tests failed: %0d", testsPassed, testsFailed);
      if (testsFailed == 0 && testsPassed > 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

   // Watchdog
   initial
   begin
      wait (limitNs != 0);
      #(limitNs);
      $display("Run timed out after %0t without finishing the patterns", $time);
      $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

// File: tests/dupTx_patterns.txt
# T name | W addr lanes data | R addr expect | P addr mask value | X byte | I intr | D
# Numbers in hex, lanes bit 0 is the low byte and bit 1 the high byte, D pulses device reset
T csrFields
R 2 4080
W 2 1 0058
R 2 40d8
W 2 2 3c00
R 2 7cd8
W 2 1 0000
R 2 7c80
T initClear
W 2 3 3c48
W 3 3 03a5
R 3 03a5
R 2 7c48
W 2 2 0100
R 2 4080
R 3 0000
W 2 3 3c48
W 3 1 0077
D
R 2 4080
R 3 0000
T doneIntr
W 2 1 0040
I 1
W 3 3 003c
I 0
R 2 4040
W 2 1 0050
P 2 0080 0080
I 1
X 3c
T dataLate
P 2 8000 8000
R 2 c2d0
W 2 2 0100
R 2 4080
I 0
T serialStream
W 2 1 0010
W 3 3 0101
P 2 0080 0080
W 3 3 00c3
P 2 0080 0080
W 3 3 025a
X 01
X c3
X 5a
P 2 0200 0000
R 2 4090
R 3 025a

// File: dupTx.f
+incdir+include
logic/dupPkg.sv
logic/dupBusDecode.sv
logic/dupTxCsr.sv
logic/dupTxDbuf.sv
logic/dupTxShifter.sv
logic/dupTx.sv
tests/dupTxTb.sv

// File: Makefile
# Verilator build and run of the DUP11 transmitter testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ps -f dupTx.f --top-module dupTxTb -o dupTxSim
	./obj_dir/dupTxSim | tee sim.log
	grep -q "^\*\*\* TEST PASSED \*\*\*$$" sim.log

clean:
	rm -rf obj_dir sim.log
